//--- weight_config.svh
`ifndef WEIGHT_CONFIG_SVH
`define WEIGHT_CONFIG_SVH

// ------------------------------------------------------------
// Weight store geometry
// ------------------------------------------------------------

// Lanes per row. Each increment carries one step per lane.
`define WM_WIDTH 16

// Rows in the store.
`define WM_DEPTH 8

// Bits per signed weight.
`define WM_BITWIDTH 8

`endif

//--- weight_pkg.sv
`include "weight_config.svh"

package weight_pkg;

    // ------------------------------------------------------------
    // Scalar types
    // ------------------------------------------------------------
    typedef logic signed [`WM_BITWIDTH-1:0] weight_t;
    typedef logic [$clog2(`WM_WIDTH)-1:0]   lane_idx_t;
    typedef logic [$clog2(`WM_DEPTH)-1:0]   row_idx_t;
    typedef logic signed [1:0]              step_t;     // Range -2 to +1.

    // Instruction word. The op bit is the MSB and the row index the LSBs.
    typedef struct packed {
        logic      op;                                  // 0 is load, 1 is increment.
        lane_idx_t lane;
        row_idx_t  row;
    } inst_t;

    // Step i sits in bits 2i+1:2i; a load value uses the low byte.
    typedef logic [2*`WM_WIDTH-1:0] data_t;

    // ------------------------------------------------------------
    // Decoded command and weight storage
    // ------------------------------------------------------------
    typedef struct packed {
        logic                     valid;
        logic                     op;
        lane_idx_t                lane;
        row_idx_t                 row;
        weight_t                  value;
        step_t [`WM_WIDTH-1:0]    steps;
    } cmd_t;

    typedef weight_t [`WM_WIDTH-1:0]     weight_row_t;
    typedef weight_row_t [`WM_DEPTH-1:0] weight_array_t;    // Indexed by row, then lane.

endpackage

//--- wm_cmd_decoder.sv
`timescale 1ns/1ps
`include "weight_config.svh"

module wm_cmd_decoder (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              exec,
    input  weight_pkg::inst_t inst,
    input  weight_pkg::data_t data,
    output weight_pkg::cmd_t  cmd
);

    weight_pkg::cmd_t cmd_next;

    // ------------------------------------------------------------
    // Field unpacking
    // ------------------------------------------------------------
    always_comb begin
        cmd_next = '0;                                  // Idle cycles leave every field at zero.
        if (exec) begin
            cmd_next.valid = 1'b1;
            cmd_next.op    = inst.op;
            cmd_next.lane  = inst.lane;
            cmd_next.row   = inst.row;
            if (inst.op) begin
                cmd_next.steps = data;                  // Lane i takes bits 2i+1:2i.
            end else begin
                cmd_next.value = weight_pkg::weight_t'(data[`WM_BITWIDTH-1:0]);
            end
        end
    end

    // One register stage; valid lasts a single cycle per strobe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd <= '0;
        end else begin
            cmd <= cmd_next;
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // An unknown strobe would corrupt the bank one cycle later.
    a_exec_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(exec)
    ) else $error("exec is unknown while out of reset.");

endmodule

//--- wm_weight_bank.sv
`timescale 1ns/1ps
`include "weight_config.svh"

module wm_weight_bank (
    input  logic                       clk,
    input  logic                       rst_n,
    input  weight_pkg::cmd_t           cmd,
    output weight_pkg::weight_array_t  weights
);

    localparam int unsigned BW = `WM_BITWIDTH;

    // Signed limits, one bit wider than a weight to compare against the sum.
    localparam logic signed [BW:0] W_MAX = {2'b00, {(BW-1){1'b1}}};
    localparam logic signed [BW:0] W_MIN = {2'b11, {(BW-1){1'b0}}};

    weight_pkg::weight_row_t cur_row;
    weight_pkg::weight_row_t inc_row;

    // ------------------------------------------------------------
    // Saturating add of one step to one weight
    // ------------------------------------------------------------
    function automatic weight_pkg::weight_t sat_add(
        input weight_pkg::weight_t w,
        input weight_pkg::step_t   s
    );
        logic signed [BW:0] sum;
        sum = w + s;                                    // Both operands sign-extend to BW+1.
        if (sum > W_MAX) begin
            return weight_pkg::weight_t'(W_MAX[BW-1:0]);
        end else if (sum < W_MIN) begin
            return weight_pkg::weight_t'(W_MIN[BW-1:0]);
        end
        return weight_pkg::weight_t'(sum[BW-1:0]);
    endfunction

    // Row under increment, taken from the array as it stands this cycle.
    assign cur_row = weights[cmd.row];

    always_comb begin
        for (int i = 0; i < `WM_WIDTH; i++) begin
            inc_row[i] = sat_add(cur_row[i], cmd.steps[i]);
        end
    end

    // ------------------------------------------------------------
    // Weight storage
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            weights <= '0;
        end else if (cmd.valid) begin
            if (cmd.op) begin
                weights[cmd.row] <= inc_row;            // All lanes of the row at once.
            end else begin
                weights[cmd.row][cmd.lane] <= cmd.value;
            end
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    // The decoder forwards the row unchanged, so an out of range row
    // means the instruction word itself was bad.
    a_row_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        cmd.valid |-> (int'(cmd.row) < `WM_DEPTH)
    ) else $error("Command row %0d is outside the store.", cmd.row);

endmodule

//--- wm_read_port.sv
`timescale 1ns/1ps
`include "weight_config.svh"

module wm_read_port (
    input  logic                       clk,
    input  logic                       rst_n,
    input  weight_pkg::inst_t          inst,
    input  weight_pkg::weight_array_t  weights,
    output weight_pkg::weight_t        read_reg
);

    weight_pkg::weight_t sel_weight;

    // ------------------------------------------------------------
    // Address decode
    // ------------------------------------------------------------
    // The address comes straight from the instruction bus, so the read
    // value follows the instruction even while no command executes.
    assign sel_weight = weights[inst.row][inst.lane];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_reg <= '0;
        end else begin
            read_reg <= sel_weight;                     // Pre-edge bank value.
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_lane_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(inst.lane) < `WM_WIDTH
    ) else $error("Read lane %0d is outside the store.", inst.lane);

endmodule

//--- weight_manager.sv
`timescale 1ns/1ps

module weight_manager (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       exec,
    input  weight_pkg::inst_t          inst,
    input  weight_pkg::data_t          data,
    output weight_pkg::weight_t        read_reg,
    output weight_pkg::weight_array_t  weights
);

    // ------------------------------------------------------------
    // Internal links
    // ------------------------------------------------------------
    weight_pkg::cmd_t cmd;                              // Decoder to bank.

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------
    wm_cmd_decoder u_cmd_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .exec  (exec),
        .inst  (inst),
        .data  (data),
        .cmd   (cmd)
    );

    // ------------------------------------------------------------
    // Weight storage
    // ------------------------------------------------------------
    wm_weight_bank u_weight_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .cmd     (cmd),
        .weights (weights)
    );

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------
    // The read address bypasses the decoder register.
    wm_read_port u_read_port (
        .clk      (clk),
        .rst_n    (rst_n),
        .inst     (inst),
        .weights  (weights),
        .read_reg (read_reg)
    );

endmodule

//--- tb_weight_manager.sv
`timescale 1ns/1ps
`include "weight_config.svh"

module tb_weight_manager;

    localparam int NUM_CELLS = `WM_WIDTH * `WM_DEPTH;
    localparam int NUM_INC   = 24;
    localparam int SAT_UP    = 260;                     // Enough +1 steps to cross the whole range.
    localparam int SAT_DOWN  = 140;
    localparam int MIX_LEN   = 48;
    localparam int PLANNED_CYCLES = 4 * NUM_CELLS + NUM_CELLS + 8 * NUM_INC
                                  + SAT_UP + SAT_DOWN + MIX_LEN + 64;

    logic                      clk;
    logic                      rst_n;
    logic                      exec;
    weight_pkg::inst_t         inst;
    weight_pkg::data_t         data;
    weight_pkg::weight_t       read_reg;
    weight_pkg::weight_array_t weights;

    weight_pkg::weight_t shadow [`WM_DEPTH][`WM_WIDTH];   // Reference copy of the store.
    weight_pkg::weight_t rd_expect;
    logic                rd_check;
    integer              seed;

    weight_manager dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .exec     (exec),
        .inst     (inst),
        .data     (data),
        .read_reg (read_reg),
        .weights  (weights)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Reference model and checks
    // ------------------------------------------------------------
    function automatic weight_pkg::weight_t expected_sum(input weight_pkg::weight_t w,
                                                         input weight_pkg::step_t s);
        int sum;
        int w_max;
        int w_min;
        w_max = (1 << (`WM_BITWIDTH - 1)) - 1;
        w_min = -(1 << (`WM_BITWIDTH - 1));
        sum = int'(w) + int'(s);
        if (sum > w_max) begin
            sum = w_max;
        end else if (sum < w_min) begin
            sum = w_min;
        end
        return sum[`WM_BITWIDTH-1:0];
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s expected 0x%h, got 0x%h", name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    // Read results land one edge after the address, so they are compared mid-cycle.
    always @(negedge clk) begin
        if (rd_check) begin
            check_value("read_reg", rd_expect, read_reg);
            rd_check <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic send_cmd(input logic op, input int lane, input int row,
                            input weight_pkg::data_t word);
        weight_pkg::inst_t cmd_inst;
        weight_pkg::step_t step;
        cmd_inst.op   = op;
        cmd_inst.lane = lane[$bits(weight_pkg::lane_idx_t)-1:0];
        cmd_inst.row  = row[$bits(weight_pkg::row_idx_t)-1:0];
        @(posedge clk);
        exec <= 1'b1;
        inst <= cmd_inst;
        data <= word;
        if (op) begin
            for (int i = 0; i < `WM_WIDTH; i++) begin
                step = word[2*i +: 2];
                shadow[row][i] = expected_sum(shadow[row][i], step);
            end
        end else begin
            shadow[row][lane] = word[`WM_BITWIDTH-1:0];
        end
    endtask

    task automatic go_idle(input int cycles);
        @(posedge clk);
        exec <= 1'b0;
        repeat (cycles) @(posedge clk);
    endtask

    task automatic read_check(input int lane, input int row);
        weight_pkg::inst_t rd_inst;
        rd_inst.op   = 1'b0;
        rd_inst.lane = lane[$bits(weight_pkg::lane_idx_t)-1:0];
        rd_inst.row  = row[$bits(weight_pkg::row_idx_t)-1:0];
        @(posedge clk);
        inst      <= rd_inst;
        rd_expect <= shadow[row][lane];
        @(posedge clk);
        rd_check <= 1'b1;
        @(negedge clk);
    endtask

    task automatic read_all();
        for (int r = 0; r < `WM_DEPTH; r++) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                read_check(l, r);
            end
        end
    endtask

    task automatic check_array();
        @(negedge clk);
        for (int r = 0; r < `WM_DEPTH; r++) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                check_value($sformatf("weights[%0d][%0d]", r, l), shadow[r][l], weights[r][l]);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        int                row;
        weight_pkg::data_t word;
        seed      = 32'h5ebb2866;
        rst_n     = 1'b0;
        exec      = 1'b0;
        inst      = '0;
        data      = '0;
        rd_check  = 1'b0;
        rd_expect = '0;
        for (int r = 0; r < `WM_DEPTH; r++) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                shadow[r][l] = '0;
            end
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        check_array();                                  // Store is clear after reset.
        read_all();

        for (int r = 0; r < `WM_DEPTH; r++) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                word = $random(seed);
                send_cmd(1'b0, l, r, word);
            end
        end
        go_idle(3);
        read_all();
        check_array();

        // Single increments; the full array check catches writes to the wrong row.
        repeat (NUM_INC) begin
            row  = {$random(seed)} % `WM_DEPTH;
            word = $random(seed);
            send_cmd(1'b1, 0, row, word);
            go_idle(3);
            check_array();
        end

        repeat (SAT_UP) send_cmd(1'b1, 0, 1, {`WM_WIDTH{2'b01}});
        repeat (SAT_DOWN) send_cmd(1'b1, 0, 2, {`WM_WIDTH{2'b10}});
        go_idle(3);
        check_array();
        for (int l = 0; l < `WM_WIDTH; l++) begin
            check_value("weights[1] at max", weight_pkg::weight_t'(8'h7f), weights[1][l]);
            check_value("weights[2] at min", weight_pkg::weight_t'(8'h80), weights[2][l]);
        end

        // Back-to-back traffic, starting with a load chased by an increment.
        word = $random(seed);
        send_cmd(1'b0, 5, 3, word);
        word = $random(seed);
        send_cmd(1'b1, 5, 3, word);
        repeat (6) begin
            word = $random(seed);
            send_cmd(1'b1, 0, 4, word);
        end
        repeat (MIX_LEN) begin
            word = $random(seed);
            send_cmd($random(seed), {$random(seed)} % `WM_WIDTH,
                     {$random(seed)} % `WM_DEPTH, word);
        end
        go_idle(3);
        check_array();
        read_check(5, 3);
        read_check(9, 4);

        $display(">>> PASS");
        $finish;
    end

    initial begin
        #(PLANNED_CYCLES * 4 * 10);
        $display("Timeout: the test sequence did not finish in time.");
        $display(">>> FAIL");
        $fatal(1, "Watchdog expired.");
    end

endmodule

//--- sim.f
+incdir+.
weight_pkg.sv
wm_cmd_decoder.sv
wm_weight_bank.sv
wm_read_port.sv
weight_manager.sv
tb_weight_manager.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_weight_manager
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) weight_config.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes.
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits non-zero on $fatal, so make reports the failure.
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
